// File: src/posPkg.sv
package posPkg;

	localparam int NumItems = 12;
	localparam int IdDigits = 4; // Digits per product ID
	localparam int NumKeys = 4;

	typedef logic [1:0] digitT; // Digit value d coded as d-1
	typedef logic [3:0] itemIdxT;
	typedef logic [NumItems-1:0] itemMaskT; // One bit per catalog item
	typedef logic [2:0] amountT; // 0 means not in cart
	typedef logic [9:0] priceT; // Cents, at most 999
	typedef logic [15:0] totalT;
	typedef logic [19:0] bcdT; // Five BCD digits
	typedef logic [2:0] kindCountT;

	typedef enum logic [2:0] {enterId, enterAmount, updateCart, checkout, showTotal} posStateT;

	// Product IDs, most significant digit first
	localparam logic [2*IdDigits-1:0] itemIdTable [NumItems] = '{
		8'b10_00_01_11, 8'b11_00_10_01, 8'b11_00_10_10, 8'b10_00_01_00,
		8'b10_00_10_10, 8'b10_01_00_11, 8'b01_00_11_10, 8'b00_01_10_11,
		8'b11_01_11_01, 8'b00_00_01_01, 8'b00_11_11_00, 8'b01_01_11_11
	};

	localparam priceT priceTable [NumItems] = '{
		10'd250, 10'd50, 10'd75, 10'd200, 10'd100, 10'd995,
		10'd50, 10'd425, 10'd999, 10'd500, 10'd550, 10'd200
	};

	// Lowest pressed key wins
	function automatic digitT keyCode(input logic [NumKeys-1:0] keys);
		digitT code;
		code = '0;
		for (int k = NumKeys - 1; k >= 0; k--)
			if (keys[k]) code = digitT'(k);
		return code;
	endfunction

endpackage

// File: src/cartIf.sv
`timescale 1ns/1ps

interface cartIf import posPkg::*; ();

	logic commit; // One-cycle purchase request
	itemIdxT itemIdx; // Valid with commit
	amountT amount; // Valid with commit
	logic clearCart; // Empties cart and total
	logic ack; // One cycle after commit
	logic accepted; // Valid with ack

	modport fsm (
		output commit, itemIdx, amount, clearCart,
		input ack, accepted
	);

	modport ledger (
		input commit, itemIdx, amount, clearCart,
		output ack, accepted
	);

endinterface

// File: src/keyDebouncer.sv
`timescale 1ns/1ps

module keyDebouncer import posPkg::*; #(
	parameter int DebounceCycles = 2
) (
	input logic CLK,
	input logic rstN,
	input logic [NumKeys-1:0] key, // Active low
	output logic [NumKeys-1:0] press,
	output logic [NumKeys-1:0] held
);

	localparam int CntW = $clog2(DebounceCycles + 2);

	logic [CntW-1:0] lowCount [NumKeys]; // Consecutive low samples, saturating

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int k = 0; k < NumKeys; k++)
				lowCount[k] <= '0;
		end else begin
			for (int k = 0; k < NumKeys; k++) begin
				if (key[k])
					lowCount[k] <= '0; // Released or bounced
				else if (lowCount[k] != CntW'(DebounceCycles + 1))
					lowCount[k] <= lowCount[k] + 1'b1;
			end
		end
	end

	// Count passes through DebounceCycles only once per stable press
	always_comb begin
		for (int k = 0; k < NumKeys; k++) begin
			press[k] = lowCount[k] == CntW'(DebounceCycles);
			held[k] = lowCount[k] == CntW'(DebounceCycles + 1);
		end
	end

endmodule

// File: src/idMatcher.sv
`timescale 1ns/1ps

module idMatcher import posPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic [NumKeys-1:0] press,
	input logic digitStrobe,
	input logic matchClear,
	output itemMaskT candidates,
	output itemIdxT itemIdx,
	output logic itemValid
);

	localparam int PosW = $clog2(IdDigits + 1);

	logic [PosW-1:0] digitPos; // Digits typed so far
	digitT digit;
	itemMaskT keep; // Items whose digit at digitPos matches

	assign digit = keyCode(press);

	always_comb begin
		keep = '1;
		if (digitPos < PosW'(IdDigits)) begin
			for (int i = 0; i < NumItems; i++)
				keep[i] = itemIdTable[i][2 * (IdDigits - 1 - int'(digitPos)) +: 2] == digit;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			candidates <= '1;
			digitPos <= '0;
		end else if (matchClear) begin
			candidates <= '1; // Fresh ID entry
			digitPos <= '0;
		end else if (digitStrobe && digitPos < PosW'(IdDigits)) begin
			candidates <= candidates & keep; // Narrow by one digit
			digitPos <= digitPos + 1'b1;
		end
	end

	// Survivor index, meaningful only when a single bit remains
	always_comb begin
		itemIdx = '0;
		for (int i = 0; i < NumItems; i++)
			if (candidates[i]) itemIdx = itemIdxT'(i);
	end

	assign itemValid = (digitPos == PosW'(IdDigits)) && (candidates != '0)
		&& ((candidates & (candidates - 1'b1)) == '0); // Exactly one candidate

endmodule

// File: src/cartLedger.sv
`timescale 1ns/1ps

module cartLedger import posPkg::*; #(
	parameter int MaxKinds = 6
) (
	input logic CLK,
	input logic rstN,
	cartIf.ledger cart,
	output totalT total,
	output kindCountT cartKinds
);

	amountT amounts [NumItems]; // Per-item amount, 0 when absent
	kindCountT kinds;
	amountT oldAmount;
	amountT amountStep; // Magnitude of the amount change
	totalT priceStep;
	logic isNew;
	logic acceptNow;
	logic growing;

	assign oldAmount = amounts[cart.itemIdx];
	assign isNew = oldAmount == '0;
	assign acceptNow = !isNew || (kinds < kindCountT'(MaxKinds)); // Rebuys always fit
	assign growing = cart.amount >= oldAmount;
	assign amountStep = growing ? cart.amount - oldAmount : oldAmount - cart.amount;
	assign priceStep = totalT'(amountStep) * totalT'(priceTable[cart.itemIdx]);
	assign cartKinds = kinds;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			cart.ack <= 1'b0;
			cart.accepted <= 1'b0;
			kinds <= '0;
			total <= '0;
			for (int i = 0; i < NumItems; i++)
				amounts[i] <= '0;
		end else begin
			cart.ack <= cart.commit; // Fixed one-cycle reply
			if (cart.clearCart) begin
				kinds <= '0; // New customer
				total <= '0;
				for (int i = 0; i < NumItems; i++)
					amounts[i] <= '0;
			end else if (cart.commit) begin
				cart.accepted <= acceptNow;
				if (acceptNow) begin
					amounts[cart.itemIdx] <= cart.amount; // Replaces any old amount
					if (growing)
						total <= total + priceStep;
					else
						total <= total - priceStep; // Smaller rebuy refunds the difference
					if (isNew)
						kinds <= kinds + 1'b1;
				end
			end
		end
	end

endmodule

// File: src/bcdConverter.sv
`timescale 1ns/1ps

module bcdConverter import posPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic convStart,
	input totalT total,
	output logic convDone,
	output bcdT totalBcd
);

	localparam int BinW = $bits(totalT);
	localparam int BcdW = $bits(bcdT);
	localparam int BcdDigits = BcdW / 4;
	localparam int StepW = $clog2(BinW);

	totalT binWork; // Remaining binary bits, MSB next
	bcdT bcdWork;
	bcdT bcdAdjusted;
	bcdT bcdNext;
	logic [StepW-1:0] step;
	logic busy;

	// Add 3 to every digit above 4 before the shift
	always_comb begin
		for (int d = 0; d < BcdDigits; d++) begin
			if (bcdWork[4*d +: 4] > 4'd4)
				bcdAdjusted[4*d +: 4] = bcdWork[4*d +: 4] + 4'd3;
			else
				bcdAdjusted[4*d +: 4] = bcdWork[4*d +: 4];
		end
	end

	assign bcdNext = {bcdAdjusted[BcdW-2:0], binWork[BinW-1]};

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			busy <= 1'b0;
			step <= '0;
			convDone <= 1'b0;
			totalBcd <= '0;
		end else begin
			convDone <= 1'b0;
			if (convStart) begin
				busy <= 1'b1;
				step <= '0;
				totalBcd <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (step == StepW'(BinW - 1)) begin // Last bit shifted in
					busy <= 1'b0;
					convDone <= 1'b1;
					totalBcd <= bcdNext;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (convStart) begin
			binWork <= total; // Snapshot of the total
			bcdWork <= '0;
		end else if (busy) begin
			binWork <= binWork << 1;
			bcdWork <= bcdNext;
		end
	end

endmodule

// File: src/checkoutFsm.sv
`timescale 1ns/1ps

module checkoutFsm import posPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic [NumKeys-1:0] press,
	input logic [NumKeys-1:0] held,
	input itemIdxT itemIdx,
	input logic itemValid,
	input logic convDone,
	cartIf.fsm cart,
	output logic digitStrobe,
	output logic matchClear,
	output logic convStart,
	output logic bcdValid
);

	localparam int DigitW = $clog2(IdDigits);

	posStateT state;
	logic [DigitW-1:0] digitCount;
	logic anyPress;
	logic checkoutCombo; // KEY0 held and KEY3 pressed

	assign anyPress = |press;
	assign checkoutCombo = held[0] & press[NumKeys-1];

	always_comb begin
		digitStrobe = 1'b0;
		matchClear = 1'b0;
		convStart = 1'b0;
		cart.clearCart = 1'b0;
		case (state)
			enterId: begin
				if (checkoutCombo) begin
					matchClear = 1'b1; // Drop partial ID
					convStart = 1'b1;
				end else if (anyPress) begin
					digitStrobe = 1'b1;
				end
			end
			enterAmount: matchClear = anyPress; // Matcher restarts after either outcome
			showTotal: begin
				cart.clearCart = checkoutCombo;
				matchClear = checkoutCombo;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= enterId;
			digitCount <= '0;
			cart.commit <= 1'b0;
			bcdValid <= 1'b0;
		end else begin
			cart.commit <= 1'b0;
			case (state)
				enterId: begin
					if (checkoutCombo) begin
						digitCount <= '0;
						state <= checkout;
					end else if (anyPress) begin
						if (digitCount == DigitW'(IdDigits - 1)) begin // Fourth digit
							digitCount <= '0;
							state <= enterAmount;
						end else begin
							digitCount <= digitCount + 1'b1;
						end
					end
				end
				enterAmount: begin
					if (anyPress && itemValid) begin
						cart.commit <= 1'b1;
						state <= updateCart;
					end else if (anyPress) begin
						state <= enterId; // Unknown ID
					end
				end
				updateCart: if (cart.ack) state <= enterId; // Presses ignored meanwhile
				checkout: begin
					if (convDone) begin
						bcdValid <= 1'b1;
						state <= showTotal;
					end
				end
				showTotal: begin
					if (checkoutCombo) begin
						bcdValid <= 1'b0;
						state <= enterId;
					end
				end
				default: state <= enterId;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == enterAmount && anyPress) begin
			cart.itemIdx <= itemIdx;
			cart.amount <= amountT'(keyCode(press)) + amountT'(1); // Key k buys k+1
		end
	end

endmodule

// File: src/itemSelector.sv
`timescale 1ns/1ps

module itemSelector import posPkg::*; #(
	parameter int DebounceCycles = 2,
	parameter int MaxKinds = 6
) (
	input logic CLK,
	input logic rstN,
	input logic [NumKeys-1:0] key, // Active low
	output itemMaskT candidates, // Autocompletion mask
	output kindCountT cartKinds,
	output bcdT totalBcd,
	output logic bcdValid
);

	logic [NumKeys-1:0] press;
	logic [NumKeys-1:0] held;
	logic digitStrobe;
	logic matchClear;
	itemIdxT itemIdx;
	logic itemValid;
	totalT total; // Binary cents
	logic convStart;
	logic convDone;

	cartIf cart ();

	keyDebouncer #(
		.DebounceCycles(DebounceCycles)
	) u_debouncer (
		.CLK(CLK), .rstN(rstN), .key(key), .press(press), .held(held)
	);

	idMatcher u_matcher (
		.CLK(CLK), .rstN(rstN), .press(press), .digitStrobe(digitStrobe),
		.matchClear(matchClear), .candidates(candidates), .itemIdx(itemIdx),
		.itemValid(itemValid)
	);

	cartLedger #(
		.MaxKinds(MaxKinds)
	) u_ledger (
		.CLK(CLK), .rstN(rstN), .cart(cart.ledger), .total(total), .cartKinds(cartKinds)
	);

	bcdConverter u_converter (
		.CLK(CLK), .rstN(rstN), .convStart(convStart), .total(total),
		.convDone(convDone), .totalBcd(totalBcd)
	);

	checkoutFsm u_fsm (
		.CLK(CLK), .rstN(rstN), .press(press), .held(held), .itemIdx(itemIdx),
		.itemValid(itemValid), .convDone(convDone), .cart(cart.fsm),
		.digitStrobe(digitStrobe), .matchClear(matchClear), .convStart(convStart),
		.bcdValid(bcdValid)
	);

endmodule

// File: verification/itemSelector_sva.sv
`timescale 1ns/1ps

module itemSelectorSva import posPkg::*; #(
	parameter int MaxKinds = 6,
	parameter bit LedgerSide = 1'b1 // Ledger checks, else FSM checks
) (
	input logic CLK,
	input logic rstN,
	input logic commit,
	input logic ack,
	input kindCountT kinds,
	input logic convStart
);

	if (LedgerSide) begin : ledgerChecks
		// Ledger replies exactly one cycle after a request
		ackAfterCommit: assert property (@(posedge CLK) disable iff (!rstN)
			commit |=> ack)
			else $error("ack missing one cycle after commit");
		ackOnlyAfterCommit: assert property (@(posedge CLK) disable iff (!rstN)
			ack |-> $past(commit))
			else $error("ack without a commit in the previous cycle");

		kindsBounded: assert property (@(posedge CLK) disable iff (!rstN)
			kinds <= kindCountT'(MaxKinds))
			else $error("cart holds more kinds than allowed");
	end else begin : fsmChecks
		convStartPulse: assert property (@(posedge CLK) disable iff (!rstN)
			convStart |=> !convStart)
			else $error("convStart longer than one cycle");
	end

endmodule

// Inputs of the other side tied off
bind cartLedger itemSelectorSva #(.MaxKinds(MaxKinds), .LedgerSide(1'b1)) u_ledgerSva (
	.CLK(CLK), .rstN(rstN), .commit(cart.commit), .ack(cart.ack), .kinds(kinds),
	.convStart(1'b0)
);

bind checkoutFsm itemSelectorSva #(.LedgerSide(1'b0)) u_fsmSva (
	.CLK(CLK), .rstN(rstN), .commit(1'b0), .ack(1'b0), .kinds(3'd0),
	.convStart(convStart)
);

// File: verification/itemSelectorTb.sv
`timescale 1ns/1ps

module itemSelectorTb import posPkg::*; ();

	localparam int MaxKinds = 6;
	localparam int Seed = 32'hbe54_fe7c;
	// About 17 purchases of 46 cycles and 4 checkouts of 40, with a wide margin
	localparam int CycleLimit = 20000;

	logic CLK = 1'b0;
	logic rstN;
	logic [NumKeys-1:0] key;
	itemMaskT candidates;
	kindCountT cartKinds;
	bcdT totalBcd;
	logic bcdValid;

	int modelAmt [NumItems]; // Model cart, 0 when absent
	bcdT expBcd;
	int expKinds;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int cycleCount = 0;
	logic bcdSeen = 1'b0;

	itemSelector #(.DebounceCycles(2), .MaxKinds(MaxKinds)) u_dut (
		.CLK(CLK), .rstN(rstN), .key(key), .candidates(candidates),
		.cartKinds(cartKinds), .totalBcd(totalBcd), .bcdValid(bcdValid)
	);

	always #50 CLK = ~CLK; // 100 ns period

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount == CycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	// Checkout result sampled on the first cycle bcdValid is seen high
	always @(posedge CLK) begin
		if (bcdValid && !bcdSeen) begin
			checkValue("totalBcd", totalBcd, expBcd);
			checkValue("cartKinds", cartKinds, expKinds);
		end
		bcdSeen <= bcdValid;
	end

	function automatic int modelKinds();
		int n;
		n = 0;
		for (int i = 0; i < NumItems; i++)
			if (modelAmt[i] != 0) n++;
		return n;
	endfunction

	// Sum of amount times price, then decimal digits
	function automatic bcdT expectedTotal();
		int sum;
		bcdT bcd;
		sum = 0;
		for (int i = 0; i < NumItems; i++)
			sum += modelAmt[i] * int'(priceTable[i]);
		for (int d = 0; d < 5; d++) begin
			bcd[4*d +: 4] = 4'(sum % 10);
			sum = sum / 10;
		end
		return bcd;
	endfunction

	// Items whose first typed digits equal those of id
	function automatic itemMaskT prefixMask(input logic [7:0] id, input int typed);
		itemMaskT mask;
		int drop;
		drop = 2 * (IdDigits - typed);
		for (int i = 0; i < NumItems; i++)
			mask[i] = (itemIdTable[i] >> drop) == (id >> drop);
		return mask;
	endfunction

	function automatic int findItem(input logic [7:0] id);
		int idx;
		idx = -1;
		for (int i = 0; i < NumItems; i++)
			if (itemIdTable[i] == id) idx = i;
		return idx;
	endfunction

	task automatic pressKey(input int k);
		@(posedge CLK);
		key[k] <= 1'b0;
		repeat (4) @(posedge CLK);
		key[k] <= 1'b1;
		repeat (4) @(posedge CLK);
	endtask

	// KEY0 held, then KEY3 pressed
	task automatic pressCombo();
		@(posedge CLK);
		key[0] <= 1'b0;
		repeat (4) @(posedge CLK);
		key[3] <= 1'b0;
		repeat (4) @(posedge CLK);
		key <= '1;
		repeat (4) @(posedge CLK);
	endtask

	task automatic enterPurchase(input logic [7:0] id, input int amt);
		int idx;
		idx = findItem(id);
		for (int p = 1; p <= IdDigits; p++) begin
			pressKey(int'(id[2*(IdDigits-p) +: 2])); // Key k is digit k+1
			@(negedge CLK);
			checkValue("candidates", candidates, prefixMask(id, p));
		end
		pressKey(amt - 1);
		if (idx >= 0 && (modelAmt[idx] != 0 || modelKinds() < MaxKinds))
			modelAmt[idx] = amt; // Rebuy replaces, full cart rejects new kinds
		@(negedge CLK);
		checkValue("cartKinds", cartKinds, modelKinds());
	endtask

	task automatic checkoutAndClear();
		expBcd = expectedTotal();
		expKinds = modelKinds();
		pressCombo();
		while (!bcdValid) @(negedge CLK);
		@(posedge CLK); // Comparator has sampled by now
		pressCombo(); // Same combination starts a new customer
		for (int i = 0; i < NumItems; i++)
			modelAmt[i] = 0;
		@(negedge CLK);
		checkValue("bcdValid", bcdValid, 1'b0);
		checkValue("cartKinds", cartKinds, 0);
		checkValue("candidates", candidates, itemMaskT'('1));
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("Test %0d %s: ok", testCount, name);
		else
			$display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
	endtask

	initial begin
		int errs;
		int a;
		int b;
		int amtA;
		logic [7:0] id;
		void'($urandom(Seed));
		rstN = 1'b0;
		key = '1; // Keys idle high
		for (int i = 0; i < NumItems; i++)
			modelAmt[i] = 0;
		repeat (16) @(posedge CLK);
		rstN <= 1'b1;
		@(negedge CLK);

		errs = errorCount;
		checkValue("candidates", candidates, itemMaskT'('1));
		checkValue("cartKinds", cartKinds, 0);
		checkValue("bcdValid", bcdValid, 1'b0);
		reportTest("reset", errs);

		errs = errorCount;
		id = 8'($urandom);
		enterPurchase(id, 1 + $urandom % 4); // Random ID, rarely a real item
		reportTest("autocompletion", errs);

		errs = errorCount;
		repeat (4) enterPurchase(itemIdTable[$urandom % NumItems], 1 + $urandom % 4);
		checkoutAndClear();
		reportTest("purchase and checkout", errs);

		errs = errorCount;
		a = $urandom % NumItems;
		b = (a + 1 + $urandom % (NumItems - 1)) % NumItems;
		amtA = 1 + $urandom % 4;
		enterPurchase(itemIdTable[a], amtA);
		enterPurchase(itemIdTable[b], 1 + $urandom % 4);
		enterPurchase(itemIdTable[a], amtA % 4 + 1); // Different amount
		checkValue("cartKinds", cartKinds, 2);
		checkoutAndClear();
		reportTest("rebuy", errs);

		errs = errorCount;
		do
			id = 8'($urandom);
		while (findItem(id) >= 0);
		enterPurchase(id, 1 + $urandom % 4); // Mask ends at zero, empty cart stays empty
		for (int i = 0; i <= MaxKinds; i++)
			enterPurchase(itemIdTable[(a + i) % NumItems], 1 + $urandom % 4);
		checkValue("cartKinds", cartKinds, MaxKinds); // Seventh kind refused
		checkoutAndClear();
		reportTest("rejections", errs);

		errs = errorCount;
		enterPurchase(itemIdTable[$urandom % NumItems], 1 + $urandom % 4);
		checkoutAndClear();
		reportTest("new customer", errs);

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: itemSelector.f
src/posPkg.sv
src/cartIf.sv
src/keyDebouncer.sv
src/idMatcher.sv
src/cartLedger.sv
src/bcdConverter.sv
src/checkoutFsm.sv
src/itemSelector.sv
verification/itemSelector_sva.sv
verification/itemSelectorTb.sv
